/* hw/barrelShifter.sv */
/*
  Pipelined 64-bit barrel shifter.
  Direction stage, one shift stage per amount bit and an output
  stage, each registered. A request sampled with inValid high
  returns on outValid SHIFTER_LATENCY cycles later.
*/

`timescale 1ns/1ps

`include "shifter_macros.svh"

module barrelShifter (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 inValid,
	input  shifter_pkg::shiftWord inData,
	input  shifter_pkg::shiftAmt  inAmt,
	input  shifter_pkg::shiftMode inMode,
	output logic                 outValid,
	output shifter_pkg::shiftWord outData
);

	import shifter_pkg::*;

	// Bus k feeds shift stage k, the last one feeds the output stage
	stageBus stageLink [0:`SHIFTER_AMT_BITS];

	// ============================================================
	// Entry
	// ============================================================

	directionStage direction0 (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inData   (inData),
		.inAmt    (inAmt),
		.inMode   (inMode),
		.stageOut (stageLink[0])
	);

	// ============================================================
	// Shift chain
	// ============================================================

	// Largest stride first, 32 down to 1 for a 64-bit word
	for (genvar k = 0; k < `SHIFTER_AMT_BITS; k++) begin : gShift
		shiftStage #(
			.stride (1 << (`SHIFTER_AMT_BITS - 1 - k))
		) shift (
			.clk      (clk),
			.rstN     (rstN),
			.stageIn  (stageLink[k]),
			.stageOut (stageLink[k+1])
		);
	end

	// ============================================================
	// Exit
	// ============================================================

	outputStage output0 (
		.clk      (clk),
		.rstN     (rstN),
		.stageIn  (stageLink[`SHIFTER_AMT_BITS]),
		.outValid (outValid),
		.outData  (outData)
	);

endmodule

/* hw/directionStage.sv */
/*
  Direction stage of the barrel shifter.
  Decodes the mode into left flag and fill bit, reverses the
  word for left shifts and registers the stage payload.
*/

`timescale 1ns/1ps

module directionStage (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 inValid,
	input  shifter_pkg::shiftWord inData,
	input  shifter_pkg::shiftAmt  inAmt,
	input  shifter_pkg::shiftMode inMode,
	output shifter_pkg::stageBus  stageOut
);

	import shifter_pkg::*;

	logic     leftSel;
	logic     fillSel;
	shiftWord dataRev;
	stageBus  nextBus;

	// ============================================================
	// Mode decode
	// ============================================================

	// Only arithmetic right copies the sign bit into the gap
	always_comb begin
		leftSel = 1'b0;
		fillSel = 1'b0;
		case (inMode)
			SHIFT_RIGHT: begin
				leftSel = 1'b0;
				fillSel = 1'b0;
			end
			SHIFT_ASR: begin
				leftSel = 1'b0;
				fillSel = inData[$bits(shiftWord)-1];
			end
			SHIFT_LEFT, SHIFT_ASL: begin
				leftSel = 1'b1;
				fillSel = 1'b0;
			end
			default: begin
				leftSel = 1'b0;
				fillSel = 1'b0;
			end
		endcase
	end

	// Left shifts run as right shifts on the mirrored word
	always_comb begin
		dataRev = {<<{inData}};
	end

	always_comb begin
		nextBus.valid = inValid;
		nextBus.left  = leftSel;
		nextBus.fill  = fillSel;
		nextBus.amt   = inAmt;
		nextBus.data  = leftSel ? dataRev : inData;
	end

	// Payload is not reset, only the strobe is cleared
	always_ff @(posedge clk) begin
		stageOut <= nextBus;
		if (!rstN) begin
			stageOut.valid <= 1'b0;
		end
	end

endmodule

/* hw/outputStage.sv */
/*
  Output stage of the barrel shifter.
  Mirrors the word back for left shifts, drops the control
  fields and registers the result and its strobe.
*/

`timescale 1ns/1ps

module outputStage (
	input  logic                 clk,
	input  logic                 rstN,
	input  shifter_pkg::stageBus  stageIn,
	output logic                 outValid,
	output shifter_pkg::shiftWord outData
);

	import shifter_pkg::*;

	shiftWord dataRev;
	shiftWord dataNext;

	// Undo the entry reversal so left results read normally
	always_comb begin
		dataRev = {<<{stageIn.data}};
	end

	always_comb begin
		if (stageIn.left) begin
			dataNext = dataRev;
		end else begin
			dataNext = stageIn.data;
		end
	end

	// ============================================================
	// Result registers
	// ============================================================

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= stageIn.valid;
		end
	end

	// Result word has no reset
	always_ff @(posedge clk) begin
		outData <= dataNext;
	end

endmodule

/* hw/shiftStage.sv */
/*
  Barrel shifter shift stage.
  Shifts the word right by a fixed stride when the matching
  amount bit is set, filling the vacated top bits with the
  fill bit, and registers the result.
*/

`timescale 1ns/1ps

module shiftStage #(
	// Power of two below the word width
	parameter int stride = 1
) (
	input  logic                clk,
	input  logic                rstN,
	input  shifter_pkg::stageBus stageIn,
	output shifter_pkg::stageBus stageOut
);

	import shifter_pkg::*;

	// Word width follows the package type
	localparam int width = $bits(shiftWord);

	// Amount bit whose weight equals the stride
	localparam int amtBit = $clog2(stride);

	logic     doShift;
	shiftWord shifted;
	stageBus  nextBus;

	// ============================================================
	// Conditional right shift by stride
	// ============================================================

	always_comb begin
		doShift = stageIn.amt[amtBit];
	end

	// Fill bit replicated into the top stride positions
	always_comb begin
		shifted = {{stride{stageIn.fill}}, stageIn.data[width-1:stride]};
	end

	always_comb begin
		nextBus.valid = stageIn.valid;
		nextBus.left  = stageIn.left;
		nextBus.fill  = stageIn.fill;
		nextBus.amt   = stageIn.amt;
		if (doShift) begin
			nextBus.data = shifted;
		end else begin
			nextBus.data = stageIn.data;
		end
	end

	// ============================================================
	// Stage register
	// ============================================================

	// Strobe clears on reset, data keeps flowing
	always_ff @(posedge clk) begin
		stageOut <= nextBus;
		if (!rstN) begin
			stageOut.valid <= 1'b0;
		end
	end

endmodule

/* hw/shifter_macros.svh */
/*
  Barrel shifter sizing constants.
  Word width, shift amount width and the pipeline depth
  from input sample to registered result.
*/

`ifndef SHIFTER_MACROS_SVH
`define SHIFTER_MACROS_SVH

// Data word width in bits
`define SHIFTER_WIDTH 64

// Shift amount width, enough to count 0 to SHIFTER_WIDTH-1
`define SHIFTER_AMT_BITS 6

// Cycles from input sample to output strobe
// One direction stage, one stage per amount bit, one output stage
`define SHIFTER_LATENCY 8

`endif

/* hw/shifter_pkg.sv */
/*
  Barrel shifter package.
  Shift mode encoding, word and amount types and the payload
  that travels between pipeline stages.
*/

`include "shifter_macros.svh"

package shifter_pkg;

	// ============================================================
	// Mode encoding
	// ============================================================

	// Bit 1 selects left, bit 0 selects arithmetic
	// Arithmetic left fills with zero, same as logical left
	typedef enum logic [1:0] {
		SHIFT_RIGHT = 2'b00,
		SHIFT_ASR   = 2'b01,
		SHIFT_LEFT  = 2'b10,
		SHIFT_ASL   = 2'b11
	} shiftMode;

	// ============================================================
	// Data types
	// ============================================================

	typedef logic [`SHIFTER_WIDTH-1:0] shiftWord;

	typedef logic [`SHIFTER_AMT_BITS-1:0] shiftAmt;

	// Payload handed from one stage to the next
	typedef struct packed {
		// One cycle strobe per item
		logic     valid;
		// Word is held bit-reversed
		logic     left;
		// Value shifted into vacated top bits
		logic     fill;
		// Remaining amount bits are consumed stage by stage
		shiftAmt  amt;
		shiftWord data;
	} stageBus;

endpackage

/* list.f */
+incdir+hw
hw/shifter_pkg.sv
hw/directionStage.sv
hw/shiftStage.sv
hw/outputStage.sv
hw/barrelShifter.sv
tests/barrelShifter_props.sv
tests/barrelShifter_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the barrel shifter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert \
	--top-module barrelShifter_tb \
	-Mdir "$BUILD" -o simv \
	-f list.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

"./$BUILD/simv" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

# The log decides the result
if grep -qx "test passed" "$LOG"; then
	echo "Run result: PASS"
	exit 0
fi

echo "Run result: FAIL, pass line not found in $LOG"
exit 1

/* tests/barrelShifter_props.sv */
/*
  Timing checks bound into the barrel shifter.
  The output strobe clears through reset and follows the
  input strobe by the pipeline latency.
*/

`timescale 1ns/1ps

`include "shifter_macros.svh"

module barrelShifter_props (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic outValid
);

	// Clean cycles since reset release, saturating at the latency
	int settled;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			settled <= 0;
		end else if (settled < `SHIFTER_LATENCY) begin
			settled <= settled + 1;
		end
	end

	// ============================================================
	// Strobe timing
	// ============================================================

	resetClearsValid: assert property (@(posedge clk) !rstN |=> !outValid)
		else $error("outValid high in the cycle after a reset edge");

	// Only checked once the whole pipeline holds post-reset traffic
	validFollowsInput: assert property (@(posedge clk) disable iff (!rstN)
		(settled == `SHIFTER_LATENCY) |-> (outValid == $past(inValid, `SHIFTER_LATENCY)))
		else $error("outValid does not match inValid delayed by the pipeline latency");

endmodule

bind barrelShifter barrelShifter_props props0 (
	.clk      (clk),
	.rstN     (rstN),
	.inValid  (inValid),
	.outValid (outValid)
);

/* tests/barrelShifter_tb.sv */
/*
  Testbench for the pipelined barrel shifter.
  Directed and LFSR random shifts are driven on the falling edge,
  results are checked in order against a shift model and the
  output strobe against the issue history.
*/

`timescale 1ns/1ps

`include "shifter_macros.svh"

module barrelShifter_tb;

	import shifter_pkg::*;

	// One request with its expected result
	typedef struct packed {
		shiftMode mode;
		shiftWord data;
		shiftAmt  amt;
		shiftWord result;
	} stimEntry;

	localparam int randomCount = 200;
	localparam int gapCount    = 120;
	localparam int gapLimit    = 16 * gapCount;
	localparam int waitLimit   = 4 * `SHIFTER_LATENCY;

	localparam shiftWord signData = 64'h8000_0000_0000_0001;
	localparam shiftWord mixData  = 64'hFEDC_BA98_7654_3210;

	logic     clk;
	logic     rstN;
	logic     inValid;
	shiftWord inData;
	shiftAmt  inAmt;
	shiftMode inMode;
	logic     outValid;
	shiftWord outData;

	logic [31:0] lfsrState;
	stimEntry    stimTable[$];
	shiftWord    expectQ[$];
	// Strobe driven on each cycle, popped when it reaches the output
	logic        validHist[$];

	barrelShifter dut0 (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inData   (inData),
		.inAmt    (inAmt),
		.inMode   (inMode),
		.outValid (outValid),
		.outData  (outData)
	);

	always #50 clk = ~clk;

	// ============================================================
	// Error reporting and compares
	// ============================================================

	task automatic reportFailure(input string line);
		$display("%s", line);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(input shiftWord got, input shiftWord exp, input string what);
		if (got !== exp) begin
			reportFailure($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic checkValid(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			reportFailure($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
				$time, what, got, exp));
		end
	endtask

	// ============================================================
	// Random source and shift model
	// ============================================================

	// Right-shifting Galois LFSR, tap mask 32'h80200003
	function automatic logic [31:0] stepLfsr(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	function automatic logic [63:0] takeBits(input int count);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = stepLfsr(lfsrState);
			r = {r[62:0], lfsrState[0]};
		end
		return r;
	endfunction

	// Sign fill only for arithmetic right, both left modes zero-fill
	function automatic shiftWord expectedShift(input shiftMode mode, input shiftWord data,
			input shiftAmt amt);
		shiftWord r;
		case (mode)
			SHIFT_ASR: r = shiftWord'($signed(data) >>> amt);
			SHIFT_LEFT, SHIFT_ASL: r = data << amt;
			default: r = data >> amt;
		endcase
		return r;
	endfunction

	function automatic stimEntry randomEntry();
		stimEntry    e;
		logic [63:0] bits;
		bits     = takeBits(2);
		e.mode   = shiftMode'(bits[1:0]);
		e.data   = takeBits(64);
		bits     = takeBits(6);
		e.amt    = bits[5:0];
		e.result = expectedShift(e.mode, e.data, e.amt);
		return e;
	endfunction

	// ============================================================
	// Stimulus table
	// ============================================================

	task automatic addEntry(input shiftMode mode, input shiftWord data, input shiftAmt amt,
			input shiftWord result);
		stimEntry e;
		e.mode   = mode;
		e.data   = data;
		e.amt    = amt;
		e.result = result;
		stimTable.push_back(e);
	endtask

	// Hand-worked results, top bit set to expose the fill
	task automatic loadDirected();
		addEntry(SHIFT_RIGHT, signData, 6'd0,  64'h8000_0000_0000_0001);
		addEntry(SHIFT_RIGHT, signData, 6'd1,  64'h4000_0000_0000_0000);
		addEntry(SHIFT_RIGHT, signData, 6'd31, 64'h0000_0001_0000_0000);
		addEntry(SHIFT_RIGHT, signData, 6'd32, 64'h0000_0000_8000_0000);
		addEntry(SHIFT_RIGHT, signData, 6'd63, 64'h0000_0000_0000_0001);
		addEntry(SHIFT_ASR,   signData, 6'd0,  64'h8000_0000_0000_0001);
		addEntry(SHIFT_ASR,   signData, 6'd1,  64'hC000_0000_0000_0000);
		addEntry(SHIFT_ASR,   signData, 6'd31, 64'hFFFF_FFFF_0000_0000);
		addEntry(SHIFT_ASR,   signData, 6'd32, 64'hFFFF_FFFF_8000_0000);
		addEntry(SHIFT_ASR,   signData, 6'd63, 64'hFFFF_FFFF_FFFF_FFFF);
		addEntry(SHIFT_LEFT,  signData, 6'd0,  64'h8000_0000_0000_0001);
		addEntry(SHIFT_LEFT,  signData, 6'd1,  64'h0000_0000_0000_0002);
		addEntry(SHIFT_LEFT,  signData, 6'd31, 64'h0000_0000_8000_0000);
		addEntry(SHIFT_LEFT,  signData, 6'd32, 64'h0000_0001_0000_0000);
		addEntry(SHIFT_LEFT,  signData, 6'd63, 64'h8000_0000_0000_0000);
		addEntry(SHIFT_ASL,   signData, 6'd0,  64'h8000_0000_0000_0001);
		addEntry(SHIFT_ASL,   signData, 6'd1,  64'h0000_0000_0000_0002);
		addEntry(SHIFT_ASL,   signData, 6'd31, 64'h0000_0000_8000_0000);
		addEntry(SHIFT_ASL,   signData, 6'd32, 64'h0000_0001_0000_0000);
		addEntry(SHIFT_ASL,   signData, 6'd63, 64'h8000_0000_0000_0000);
		addEntry(SHIFT_RIGHT, mixData,  6'd4,  64'h0FED_CBA9_8765_4321);
		addEntry(SHIFT_ASR,   mixData,  6'd4,  64'hFFED_CBA9_8765_4321);
		addEntry(SHIFT_ASR,   mixData,  6'd8,  64'hFFFE_DCBA_9876_5432);
		addEntry(SHIFT_LEFT,  mixData,  6'd4,  64'hEDCB_A987_6543_2100);
		addEntry(SHIFT_ASL,   mixData,  6'd8,  64'hDCBA_9876_5432_1000);
	endtask

	// ============================================================
	// Cycle handling
	// ============================================================

	// Each tick must be followed by exactly one issue or driveIdle
	task automatic tick();
		logic     expValid;
		shiftWord expWord;
		@(negedge clk);
		expValid = validHist.pop_front();
		checkValid(outValid, expValid, "outValid");
		if (outValid) begin
			if (expectQ.size() == 0) begin
				reportFailure("outValid went high with no request outstanding");
			end else begin
				expWord = expectQ.pop_front();
				checkWord(outData, expWord, "outData");
			end
		end
	endtask

	task automatic issue(input stimEntry e);
		inValid = 1'b1;
		inData  = e.data;
		inAmt   = e.amt;
		inMode  = e.mode;
		expectQ.push_back(e.result);
		validHist.push_back(1'b1);
	endtask

	task automatic driveIdle();
		inValid = 1'b0;
		validHist.push_back(1'b0);
	endtask

	task automatic drainResults();
		int cyc;
		cyc = 0;
		while (expectQ.size() != 0 && cyc < waitLimit) begin
			tick();
			driveIdle();
			cyc++;
		end
		if (expectQ.size() != 0) begin
			reportFailure("Timed out waiting for outstanding results to drain");
		end
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		int          idx;
		int          cyc;
		int          base;
		logic        seen;
		logic [63:0] gapBit;
		clk       = 1'b0;
		rstN      = 1'b0;
		inValid   = 1'b0;
		inData    = '0;
		inAmt     = '0;
		inMode    = SHIFT_RIGHT;
		lfsrState = 32'h8386364f;
		loadDirected();
		for (int i = 0; i < `SHIFTER_LATENCY; i++) begin
			validHist.push_back(1'b0);
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Quiet pipeline before any request
		repeat (12) begin
			tick();
			driveIdle();
		end

		// Directed rows one at a time, latency held by the history check
		for (idx = 0; idx < stimTable.size(); idx++) begin
			tick();
			issue(stimTable[idx]);
			seen = 1'b0;
			for (cyc = 0; cyc < waitLimit && !seen; cyc++) begin
				tick();
				driveIdle();
				seen = outValid;
			end
			if (!seen) begin
				reportFailure("Timed out waiting for outValid after a single request");
			end
		end

		// Back-to-back random traffic, eight items in flight
		base = stimTable.size();
		for (int i = 0; i < randomCount; i++) begin
			stimTable.push_back(randomEntry());
		end
		for (idx = base; idx < stimTable.size(); idx++) begin
			tick();
			issue(stimTable[idx]);
		end
		drainResults();

		// Random idle cycles between requests
		base = stimTable.size();
		for (int i = 0; i < gapCount; i++) begin
			stimTable.push_back(randomEntry());
		end
		idx = base;
		cyc = 0;
		while (idx < stimTable.size() && cyc < gapLimit) begin
			tick();
			gapBit = takeBits(1);
			if (gapBit[0]) begin
				issue(stimTable[idx]);
				idx++;
			end else begin
				driveIdle();
			end
			cyc++;
		end
		if (idx < stimTable.size()) begin
			reportFailure("Gap traffic ran out of cycles before every request was issued");
		end
		drainResults();

		// Tail catches any late or spurious strobe
		repeat (`SHIFTER_LATENCY + 4) begin
			tick();
			driveIdle();
		end

		if (expectQ.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			reportFailure("Results left outstanding at the end of the run");
		end
	end

endmodule
